//--- flist.f
rtl/decode_pkg.sv
rtl/control_decoder.sv
rtl/operand_extractor.sv
rtl/decode_register.sv
rtl/decode_stage.sv
sim/tb_decode_stage.sv

//--- rtl/control_decoder.sv
`timescale 1ns/1ps

module control_decoder (
	input logic [6:0] opcode,
	output logic legal,
	output decode_pkg::alu_op_t alu_op,
	output logic [2:0] branch_cond,
	output logic op1_ra,
	output logic op1_rb,
	output logic op2_rb,
	output logic mem_load,
	output logic mem_store,
	output decode_pkg::mem_width_t mem_width,
	output logic is_call,
	output logic update_rd,
	output logic update_flags,
	output logic update_carry,
	output logic write_cr,
	output logic is_swi,
	output logic is_rfe,
	output decode_pkg::imm_form_t imm_form,
	output logic rd_is_lr
);

	import decode_pkg::*;

	opcode_t op;

	assign op = opcode_t'(opcode);

	always_comb begin
		legal = 1'b0;
		alu_op = ALU_ADD;
		branch_cond = 3'd0;
		op1_ra = 1'b0;
		op1_rb = 1'b0;
		op2_rb = 1'b0;
		mem_load = 1'b0;
		mem_store = 1'b0;
		mem_width = W32;
		is_call = 1'b0;
		update_rd = 1'b0;
		update_flags = 1'b0;
		update_carry = 1'b0;
		write_cr = 1'b0;
		is_swi = 1'b0;
		is_rfe = 1'b0;
		imm_form = IMM13;
		rd_is_lr = 1'b0;

		case (op)
		// ####################
		// ALU class
		// ####################
		OPC_ADD, OPC_SUB, OPC_LSL, OPC_LSR, OPC_AND, OPC_OR, OPC_XOR, OPC_CMP: begin
			legal = 1'b1;
			op1_ra = 1'b1;
			op2_rb = 1'b1;
			update_flags = 1'b1;
			// compare only sets flags
			update_rd = (op != OPC_CMP);
			case (op)
			OPC_SUB, OPC_CMP: alu_op = ALU_SUB;
			OPC_LSL: alu_op = ALU_LSL;
			OPC_LSR: alu_op = ALU_LSR;
			OPC_AND: alu_op = ALU_AND;
			OPC_OR: alu_op = ALU_OR;
			OPC_XOR: alu_op = ALU_XOR;
			default: alu_op = ALU_ADD;
			endcase
		end
		// the carry forms take their second operand from IMM13
		OPC_ADDC, OPC_SUBC: begin
			legal = 1'b1;
			op1_ra = 1'b1;
			update_rd = 1'b1;
			update_flags = 1'b1;
			update_carry = 1'b1;
			alu_op = (op == OPC_ADDC) ? ALU_ADDC : ALU_SUBC;
		end
		OPC_MOVHI: begin
			legal = 1'b1;
			op1_ra = 1'b1;
			update_rd = 1'b1;
			alu_op = ALU_COPYB;
			imm_form = HI16;
		end
		OPC_ORLO: begin
			legal = 1'b1;
			op1_ra = 1'b1;
			update_rd = 1'b1;
			alu_op = ALU_OR;
			imm_form = LO16;
		end
		// ####################
		// branch class
		// ####################
		OPC_B, OPC_CALL, OPC_BCC: begin
			legal = 1'b1;
			imm_form = IMM24;
			branch_cond = (op == OPC_BCC) ? 3'd1 : 3'd0;
			if (op == OPC_CALL) begin
				is_call = 1'b1;
				update_rd = 1'b1;
				rd_is_lr = 1'b1;
			end
		end
		// ####################
		// memory class
		// ####################
		OPC_LDR32, OPC_LDR16, OPC_LDR8, OPC_STR32, OPC_STR16, OPC_STR8: begin
			legal = 1'b1;
			op1_ra = 1'b1;
			// bit 2 of the opcode separates stores from loads
			mem_store = opcode[2];
			mem_load = ~opcode[2];
			update_rd = ~opcode[2];
			op2_rb = opcode[2];
			case (opcode[1:0])
			2'd1: mem_width = W16;
			2'd2: mem_width = W8;
			default: mem_width = W32;
			endcase
		end
		// ####################
		// system class
		// ####################
		OPC_SWI: begin
			legal = 1'b1;
			is_swi = 1'b1;
		end
		OPC_RFE: begin
			legal = 1'b1;
			is_rfe = 1'b1;
		end
		OPC_GCR: begin
			legal = 1'b1;
			update_rd = 1'b1;
			alu_op = ALU_GCR;
		end
		OPC_SCR: begin
			legal = 1'b1;
			write_cr = 1'b1;
			op1_ra = 1'b1;
		end
		default: begin
			legal = 1'b0;
		end
		endcase
	end

endmodule

//--- rtl/decode_pkg.sv
package decode_pkg;

	// ####################
	// widths and fixed registers
	// ####################

	localparam int WORD_W = 32;
	localparam int REG_SEL_W = 4;
	localparam int CR_SEL_W = 3;

	// CALL writes its return address here
	localparam int LINK_REG = 15;

	// ####################
	// opcodes
	// ####################

	// bits 31:25 of the instruction where the top two bits give the class
	typedef enum logic [6:0] {
		// class 0 holds the ALU operations
		OPC_ADD = 7'h00,
		OPC_ADDC = 7'h01,
		OPC_SUB = 7'h02,
		OPC_SUBC = 7'h03,
		OPC_LSL = 7'h04,
		OPC_LSR = 7'h05,
		OPC_AND = 7'h06,
		OPC_OR = 7'h07,
		OPC_XOR = 7'h08,
		OPC_CMP = 7'h09,
		OPC_MOVHI = 7'h0a,
		OPC_ORLO = 7'h0b,
		// class 1 holds the branches
		OPC_B = 7'h28,
		OPC_CALL = 7'h29,
		OPC_BCC = 7'h2a,
		// class 2 holds the memory accesses
		OPC_LDR32 = 7'h40,
		OPC_LDR16 = 7'h41,
		OPC_LDR8 = 7'h42,
		OPC_STR32 = 7'h44,
		OPC_STR16 = 7'h45,
		OPC_STR8 = 7'h46,
		// class 3 holds the system operations
		OPC_SWI = 7'h60,
		OPC_RFE = 7'h61,
		OPC_GCR = 7'h62,
		OPC_SCR = 7'h63
	} opcode_t;

	// ####################
	// execute stage controls
	// ####################

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_ADDC = 5'd1,
		ALU_SUB = 5'd2,
		ALU_SUBC = 5'd3,
		ALU_LSL = 5'd4,
		ALU_LSR = 5'd5,
		ALU_AND = 5'd6,
		ALU_OR = 5'd7,
		ALU_XOR = 5'd8,
		// operand 2 goes straight through
		ALU_COPYB = 5'd9,
		ALU_GCR = 5'd10
	} alu_op_t;

	typedef enum logic [1:0] {
		IMM13 = 2'd0,
		IMM24 = 2'd1,
		HI16 = 2'd2,
		LO16 = 2'd3
	} imm_form_t;

	typedef enum logic [1:0] {
		W32 = 2'd0,
		W16 = 2'd1,
		W8 = 2'd2
	} mem_width_t;

endpackage

//--- rtl/decode_register.sv
`timescale 1ns/1ps

module decode_register (
	input logic clk,
	input logic rst,
	input logic [1:0] instr_class,
	input logic legal,
	input decode_pkg::alu_op_t alu_op,
	input logic [2:0] branch_cond,
	input logic op1_ra,
	input logic op1_rb,
	input logic op2_rb,
	input logic mem_load,
	input logic mem_store,
	input decode_pkg::mem_width_t mem_width,
	input logic is_call,
	input logic update_rd,
	input logic update_flags,
	input logic update_carry,
	input logic write_cr,
	input logic is_swi,
	input logic is_rfe,
	input decode_pkg::imm_form_t imm_form,
	input logic rd_is_lr,
	input logic [decode_pkg::REG_SEL_W-1:0] rd_field,
	input logic [decode_pkg::CR_SEL_W-1:0] cr_field,
	input logic [decode_pkg::WORD_W-1:0] imm13,
	input logic [decode_pkg::WORD_W-1:0] imm24,
	input logic [decode_pkg::WORD_W-1:0] hi16,
	input logic [decode_pkg::WORD_W-1:0] lo16,
	input logic [decode_pkg::WORD_W-1:0] pc_plus_4,
	input logic fetched,
	input logic exception_start_in,
	output logic [decode_pkg::REG_SEL_W-1:0] rd_sel,
	output logic update_rd_out,
	output logic [decode_pkg::WORD_W-1:0] imm32,
	output decode_pkg::alu_op_t alu_opc,
	output logic [2:0] branch_condition,
	output logic alu_op1_ra,
	output logic alu_op1_rb,
	output logic alu_op2_rb,
	output logic mem_load_out,
	output logic mem_store_out,
	output decode_pkg::mem_width_t mem_width_out,
	output logic [1:0] instr_class_out,
	output logic is_call_out,
	output logic update_flags_out,
	output logic update_carry_out,
	output logic [decode_pkg::CR_SEL_W-1:0] cr_sel,
	output logic write_cr_out,
	output logic is_swi_out,
	output logic is_rfe_out,
	output logic [decode_pkg::WORD_W-1:0] pc_plus_4_out,
	output logic exception_start_out,
	output logic valid_out
);

	import decode_pkg::*;

	logic [WORD_W-1:0] imm_next;
	logic [REG_SEL_W-1:0] rd_next;

	always_comb begin
		case (imm_form)
		IMM24: imm_next = imm24;
		HI16: imm_next = hi16;
		LO16: imm_next = lo16;
		default: imm_next = imm13;
		endcase
	end

	assign rd_next = rd_is_lr ? REG_SEL_W'(LINK_REG) : rd_field;

	// ####################
	// state-affecting controls
	// ####################

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
			update_rd_out <= 1'b0;
			update_flags_out <= 1'b0;
			update_carry_out <= 1'b0;
			mem_load_out <= 1'b0;
			mem_store_out <= 1'b0;
			is_call_out <= 1'b0;
			write_cr_out <= 1'b0;
			is_swi_out <= 1'b0;
			is_rfe_out <= 1'b0;
			exception_start_out <= 1'b0;
			pc_plus_4_out <= '0;
			instr_class_out <= 2'b00;
		end else begin
			valid_out <= legal & fetched;
			update_rd_out <= update_rd;
			update_flags_out <= update_flags;
			update_carry_out <= update_carry;
			mem_load_out <= mem_load;
			mem_store_out <= mem_store;
			is_call_out <= is_call;
			write_cr_out <= write_cr;
			is_swi_out <= is_swi;
			is_rfe_out <= is_rfe;
			// an illegal opcode traps just like a software interrupt
			exception_start_out <= ~legal | is_swi | exception_start_in;
			pc_plus_4_out <= pc_plus_4;
			instr_class_out <= instr_class;
		end
	end

	// ####################
	// data fields
	// ####################

	always_ff @(posedge clk) begin
		rd_sel <= rd_next;
		imm32 <= imm_next;
		alu_opc <= alu_op;
		branch_condition <= branch_cond;
		alu_op1_ra <= op1_ra;
		alu_op1_rb <= op1_rb;
		alu_op2_rb <= op2_rb;
		mem_width_out <= mem_width;
		cr_sel <= cr_field;
	end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
	input logic clk,
	input logic rst,
	input logic [decode_pkg::WORD_W-1:0] instr,
	input logic [decode_pkg::WORD_W-1:0] pc_plus_4,
	input logic fetched,
	input logic exception_start_in,
	output logic [decode_pkg::REG_SEL_W-1:0] ra_sel,
	output logic [decode_pkg::REG_SEL_W-1:0] rb_sel,
	output logic illegal_instr,
	output logic [decode_pkg::REG_SEL_W-1:0] rd_sel,
	output logic update_rd_out,
	output logic [decode_pkg::WORD_W-1:0] imm32,
	output decode_pkg::alu_op_t alu_opc,
	output logic [2:0] branch_condition,
	output logic alu_op1_ra,
	output logic alu_op1_rb,
	output logic alu_op2_rb,
	output logic mem_load_out,
	output logic mem_store_out,
	output decode_pkg::mem_width_t mem_width_out,
	output logic [1:0] instr_class_out,
	output logic is_call_out,
	output logic update_flags_out,
	output logic update_carry_out,
	output logic [decode_pkg::CR_SEL_W-1:0] cr_sel,
	output logic write_cr_out,
	output logic is_swi_out,
	output logic is_rfe_out,
	output logic [decode_pkg::WORD_W-1:0] pc_plus_4_out,
	output logic exception_start_out,
	output logic valid_out
);

	import decode_pkg::*;

	logic legal;
	alu_op_t alu_op;
	logic [2:0] branch_cond;
	logic op1_ra;
	logic op1_rb;
	logic op2_rb;
	logic mem_load;
	logic mem_store;
	mem_width_t mem_width;
	logic is_call;
	logic update_rd;
	logic update_flags;
	logic update_carry;
	logic write_cr;
	logic is_swi;
	logic is_rfe;
	imm_form_t imm_form;
	logic rd_is_lr;
	logic [REG_SEL_W-1:0] rd_field;
	logic [CR_SEL_W-1:0] cr_field;
	logic [WORD_W-1:0] imm13;
	logic [WORD_W-1:0] imm24;
	logic [WORD_W-1:0] hi16;
	logic [WORD_W-1:0] lo16;

	assign illegal_instr = ~legal;

	control_decoder i_control_decoder (
		.opcode(instr[31:25]),
		.legal(legal),
		.alu_op(alu_op),
		.branch_cond(branch_cond),
		.op1_ra(op1_ra),
		.op1_rb(op1_rb),
		.op2_rb(op2_rb),
		.mem_load(mem_load),
		.mem_store(mem_store),
		.mem_width(mem_width),
		.is_call(is_call),
		.update_rd(update_rd),
		.update_flags(update_flags),
		.update_carry(update_carry),
		.write_cr(write_cr),
		.is_swi(is_swi),
		.is_rfe(is_rfe),
		.imm_form(imm_form),
		.rd_is_lr(rd_is_lr)
	);

	operand_extractor i_operand_extractor (
		.instr(instr),
		.ra_sel(ra_sel),
		.rb_sel(rb_sel),
		.rd_field(rd_field),
		.cr_field(cr_field),
		.imm13(imm13),
		.imm24(imm24),
		.hi16(hi16),
		.lo16(lo16)
	);

	decode_register i_decode_register (
		.clk(clk),
		.rst(rst),
		.instr_class(instr[31:30]),
		.legal(legal),
		.alu_op(alu_op),
		.branch_cond(branch_cond),
		.op1_ra(op1_ra),
		.op1_rb(op1_rb),
		.op2_rb(op2_rb),
		.mem_load(mem_load),
		.mem_store(mem_store),
		.mem_width(mem_width),
		.is_call(is_call),
		.update_rd(update_rd),
		.update_flags(update_flags),
		.update_carry(update_carry),
		.write_cr(write_cr),
		.is_swi(is_swi),
		.is_rfe(is_rfe),
		.imm_form(imm_form),
		.rd_is_lr(rd_is_lr),
		.rd_field(rd_field),
		.cr_field(cr_field),
		.imm13(imm13),
		.imm24(imm24),
		.hi16(hi16),
		.lo16(lo16),
		.pc_plus_4(pc_plus_4),
		.fetched(fetched),
		.exception_start_in(exception_start_in),
		.rd_sel(rd_sel),
		.update_rd_out(update_rd_out),
		.imm32(imm32),
		.alu_opc(alu_opc),
		.branch_condition(branch_condition),
		.alu_op1_ra(alu_op1_ra),
		.alu_op1_rb(alu_op1_rb),
		.alu_op2_rb(alu_op2_rb),
		.mem_load_out(mem_load_out),
		.mem_store_out(mem_store_out),
		.mem_width_out(mem_width_out),
		.instr_class_out(instr_class_out),
		.is_call_out(is_call_out),
		.update_flags_out(update_flags_out),
		.update_carry_out(update_carry_out),
		.cr_sel(cr_sel),
		.write_cr_out(write_cr_out),
		.is_swi_out(is_swi_out),
		.is_rfe_out(is_rfe_out),
		.pc_plus_4_out(pc_plus_4_out),
		.exception_start_out(exception_start_out),
		.valid_out(valid_out)
	);

endmodule

//--- rtl/operand_extractor.sv
`timescale 1ns/1ps

module operand_extractor (
	input logic [decode_pkg::WORD_W-1:0] instr,
	output logic [decode_pkg::REG_SEL_W-1:0] ra_sel,
	output logic [decode_pkg::REG_SEL_W-1:0] rb_sel,
	output logic [decode_pkg::REG_SEL_W-1:0] rd_field,
	output logic [decode_pkg::CR_SEL_W-1:0] cr_field,
	output logic [decode_pkg::WORD_W-1:0] imm13,
	output logic [decode_pkg::WORD_W-1:0] imm24,
	output logic [decode_pkg::WORD_W-1:0] hi16,
	output logic [decode_pkg::WORD_W-1:0] lo16
);

	import decode_pkg::*;

	// ####################
	// register fields
	// ####################

	assign ra_sel = instr[11:8];
	assign rb_sel = instr[7:4];
	assign rd_field = instr[3:0];
	assign cr_field = instr[14:12];

	// ####################
	// immediate candidates
	// ####################

	// ALU and memory offsets are signed
	assign imm13 = {{(WORD_W - 13){instr[24]}}, instr[24:12]};

	// branch offset is in words, so scale it to bytes
	assign imm24 = {{(WORD_W - 26){instr[23]}}, instr[23:0], 2'b00};

	// movhi and orlo build a constant in two halves
	assign hi16 = {instr[25:10], {(WORD_W - 16){1'b0}}};
	assign lo16 = {{(WORD_W - 16){1'b0}}, instr[25:10]};

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tb_decode_stage -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "compilation failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_decode_stage)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Test passed$"; then
	exit 0
fi

echo "pass message not found in simulation output"
exit 1

//--- sim/tb_decode_stage.sv
`timescale 1ns/1ps

module tb_decode_stage;

	import decode_pkg::*;

	localparam int NUM_INSTR = 2000;
	localparam int RESET_CYCLES = 4;
	// covers reset, one settle cycle, the run and a drain cycle with some margin
	localparam int TIMEOUT_CYCLES = NUM_INSTR + RESET_CYCLES + 96;

	// legal opcodes of the instruction set listed class by class
	localparam logic [6:0] LEGAL_OPS [25] = '{
		7'h00, 7'h01, 7'h02, 7'h03, 7'h04, 7'h05, 7'h06, 7'h07, 7'h08, 7'h09, 7'h0a, 7'h0b,
		7'h28, 7'h29, 7'h2a,
		7'h40, 7'h41, 7'h42, 7'h44, 7'h45, 7'h46,
		7'h60, 7'h61, 7'h62, 7'h63
	};

	typedef struct packed {
		logic legal;
		logic [4:0] alu;
		logic [2:0] bcond;
		logic op1_ra;
		logic op1_rb;
		logic op2_rb;
		logic load;
		logic store;
		logic [1:0] width;
		logic call;
		logic upd_rd;
		logic upd_flags;
		logic upd_carry;
		logic wr_cr;
		logic swi;
		logic rfe;
		logic [1:0] form;
		logic lr;
	} ctrl_t;

	logic clk;
	logic rst;
	logic [31:0] instr;
	logic [31:0] pc_plus_4;
	logic fetched;
	logic exception_start_in;
	logic [3:0] ra_sel;
	logic [3:0] rb_sel;
	logic illegal_instr;
	logic [3:0] rd_sel;
	logic update_rd_out;
	logic [31:0] imm32;
	alu_op_t alu_opc;
	logic [2:0] branch_condition;
	logic alu_op1_ra;
	logic alu_op1_rb;
	logic alu_op2_rb;
	logic mem_load_out;
	logic mem_store_out;
	mem_width_t mem_width_out;
	logic [1:0] instr_class_out;
	logic is_call_out;
	logic update_flags_out;
	logic update_carry_out;
	logic [2:0] cr_sel;
	logic write_cr_out;
	logic is_swi_out;
	logic is_rfe_out;
	logic [31:0] pc_plus_4_out;
	logic exception_start_out;
	logic valid_out;

	logic [31:0] rng_state;
	int errors;
	int checks;
	int cycle_count;
	int i;
	logic [31:0] sel;
	logic [31:0] body;
	logic [31:0] w;
	logic [31:0] pc;
	logic [4:0] idx;
	logic f;
	logic ex;

	// expectation for the instruction captured at the next rising edge
	ctrl_t want;
	logic [31:0] want_imm;
	logic [3:0] want_rd;
	logic [2:0] want_cr;
	logic [31:0] want_pc;
	logic [1:0] want_class;
	logic want_valid;
	logic want_exc;

	decode_stage i_decode_stage (
		.clk(clk), .rst(rst), .instr(instr), .pc_plus_4(pc_plus_4),
		.fetched(fetched), .exception_start_in(exception_start_in),
		.ra_sel(ra_sel), .rb_sel(rb_sel), .illegal_instr(illegal_instr),
		.rd_sel(rd_sel), .update_rd_out(update_rd_out), .imm32(imm32),
		.alu_opc(alu_opc), .branch_condition(branch_condition),
		.alu_op1_ra(alu_op1_ra), .alu_op1_rb(alu_op1_rb), .alu_op2_rb(alu_op2_rb),
		.mem_load_out(mem_load_out), .mem_store_out(mem_store_out),
		.mem_width_out(mem_width_out), .instr_class_out(instr_class_out),
		.is_call_out(is_call_out), .update_flags_out(update_flags_out),
		.update_carry_out(update_carry_out), .cr_sel(cr_sel),
		.write_cr_out(write_cr_out), .is_swi_out(is_swi_out), .is_rfe_out(is_rfe_out),
		.pc_plus_4_out(pc_plus_4_out), .exception_start_out(exception_start_out),
		.valid_out(valid_out)
	);

	always #50 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] draw_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// ####################
	// reference model
	// ####################

	function automatic ctrl_t model_decode(input logic [6:0] opc);
		ctrl_t c;
		c = '0;
		if (opc <= 7'h0b) begin
			c.legal = 1'b1;
			c.op1_ra = 1'b1;
			c.upd_rd = (opc != 7'h09);
			c.upd_flags = !(opc inside {7'h0a, 7'h0b});
			c.upd_carry = opc inside {7'h01, 7'h03};
			c.op2_rb = !(opc inside {7'h01, 7'h03, 7'h0a, 7'h0b});
			case (opc)
			7'h01: c.alu = ALU_ADDC;
			7'h02: c.alu = ALU_SUB;
			7'h03: c.alu = ALU_SUBC;
			7'h04: c.alu = ALU_LSL;
			7'h05: c.alu = ALU_LSR;
			7'h06: c.alu = ALU_AND;
			7'h07: c.alu = ALU_OR;
			7'h08: c.alu = ALU_XOR;
			// compare is a subtract that keeps only the flags
			7'h09: c.alu = ALU_SUB;
			7'h0a: c.alu = ALU_COPYB;
			7'h0b: c.alu = ALU_OR;
			default: c.alu = ALU_ADD;
			endcase
			if (opc == 7'h0a)
				c.form = HI16;
			if (opc == 7'h0b)
				c.form = LO16;
		end else if (opc inside {7'h28, 7'h29, 7'h2a}) begin
			c.legal = 1'b1;
			c.form = IMM24;
			c.alu = ALU_ADD;
			c.bcond = (opc == 7'h2a) ? 3'd1 : 3'd0;
			c.call = (opc == 7'h29);
			c.upd_rd = (opc == 7'h29);
			c.lr = (opc == 7'h29);
		end else if (opc inside {7'h40, 7'h41, 7'h42, 7'h44, 7'h45, 7'h46}) begin
			c.legal = 1'b1;
			c.op1_ra = 1'b1;
			c.alu = ALU_ADD;
			c.form = IMM13;
			c.load = opc inside {7'h40, 7'h41, 7'h42};
			c.store = !c.load;
			c.upd_rd = c.load;
			c.op2_rb = c.store;
			if (opc inside {7'h41, 7'h45})
				c.width = W16;
			else if (opc inside {7'h42, 7'h46})
				c.width = W8;
			else
				c.width = W32;
		end else begin
			c.legal = opc inside {7'h60, 7'h61, 7'h62, 7'h63};
			c.swi = (opc == 7'h60);
			c.rfe = (opc == 7'h61);
			c.upd_rd = (opc == 7'h62);
			c.alu = (opc == 7'h62) ? ALU_GCR : ALU_ADD;
			c.wr_cr = (opc == 7'h63);
			c.op1_ra = (opc == 7'h63);
		end
		return c;
	endfunction

	task automatic predict(input logic [31:0] word, input logic [31:0] pc4, input logic fet,
			input logic exc_in);
		want = model_decode(word[31:25]);
		case (want.form)
		IMM24: want_imm = 32'($signed(word[23:0])) << 2;
		HI16: want_imm = {word[25:10], 16'h0000};
		LO16: want_imm = {16'h0000, word[25:10]};
		default: want_imm = 32'($signed(word[24:12]));
		endcase
		want_rd = want.lr ? 4'(LINK_REG) : word[3:0];
		want_cr = word[14:12];
		want_pc = pc4;
		want_class = word[31:30];
		want_valid = want.legal & fet;
		want_exc = ~want.legal | want.swi | exc_in;
	endtask

	// ####################
	// checks
	// ####################

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t: %s is %0h, expected %0h", $time, name, got, expected);
		end
	endtask

	task automatic check_reset_state();
		check_field("valid_out", 32'(valid_out), 32'd0);
		check_field("update_rd_out", 32'(update_rd_out), 32'd0);
		check_field("update_flags_out", 32'(update_flags_out), 32'd0);
		check_field("update_carry_out", 32'(update_carry_out), 32'd0);
		check_field("mem_load_out", 32'(mem_load_out), 32'd0);
		check_field("mem_store_out", 32'(mem_store_out), 32'd0);
		check_field("is_call_out", 32'(is_call_out), 32'd0);
		check_field("write_cr_out", 32'(write_cr_out), 32'd0);
		check_field("is_swi_out", 32'(is_swi_out), 32'd0);
		check_field("is_rfe_out", 32'(is_rfe_out), 32'd0);
		check_field("exception_start_out", 32'(exception_start_out), 32'd0);
		check_field("pc_plus_4_out", pc_plus_4_out, 32'd0);
		check_field("instr_class_out", 32'(instr_class_out), 32'd0);
	endtask

	task automatic check_combinational();
		ctrl_t c;
		c = model_decode(instr[31:25]);
		check_field("ra_sel", 32'(ra_sel), 32'(instr[11:8]));
		check_field("rb_sel", 32'(rb_sel), 32'(instr[7:4]));
		check_field("illegal_instr", 32'(illegal_instr), 32'(!c.legal));
	endtask

	task automatic check_registered();
		check_field("valid_out", 32'(valid_out), 32'(want_valid));
		check_field("exception_start_out", 32'(exception_start_out), 32'(want_exc));
		check_field("alu_opc", 32'(alu_opc), 32'(want.alu));
		check_field("branch_condition", 32'(branch_condition), 32'(want.bcond));
		check_field("alu_op1_ra", 32'(alu_op1_ra), 32'(want.op1_ra));
		check_field("alu_op1_rb", 32'(alu_op1_rb), 32'(want.op1_rb));
		check_field("alu_op2_rb", 32'(alu_op2_rb), 32'(want.op2_rb));
		check_field("mem_load_out", 32'(mem_load_out), 32'(want.load));
		check_field("mem_store_out", 32'(mem_store_out), 32'(want.store));
		check_field("mem_width_out", 32'(mem_width_out), 32'(want.width));
		check_field("is_call_out", 32'(is_call_out), 32'(want.call));
		check_field("update_rd_out", 32'(update_rd_out), 32'(want.upd_rd));
		check_field("update_flags_out", 32'(update_flags_out), 32'(want.upd_flags));
		check_field("update_carry_out", 32'(update_carry_out), 32'(want.upd_carry));
		check_field("write_cr_out", 32'(write_cr_out), 32'(want.wr_cr));
		check_field("is_swi_out", 32'(is_swi_out), 32'(want.swi));
		check_field("is_rfe_out", 32'(is_rfe_out), 32'(want.rfe));
		check_field("imm32", imm32, want_imm);
		check_field("rd_sel", 32'(rd_sel), 32'(want_rd));
		check_field("cr_sel", 32'(cr_sel), 32'(want_cr));
		check_field("pc_plus_4_out", pc_plus_4_out, want_pc);
		check_field("instr_class_out", 32'(instr_class_out), 32'(want_class));
	endtask

	// ####################
	// stimulus
	// ####################

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		instr = 32'd0;
		pc_plus_4 = 32'd0;
		fetched = 1'b0;
		exception_start_in = 1'b0;
		rng_state = 32'd11;
		errors = 0;
		checks = 0;
		for (i = 0; i < RESET_CYCLES - 1; i++) begin
			@(posedge clk);
			@(negedge clk);
			check_reset_state();
		end
		@(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_reset_state();
		predict(instr, pc_plus_4, fetched, exception_start_in);
		for (i = 0; i < NUM_INSTR; i++) begin
			@(posedge clk);
			sel = draw_random();
			body = draw_random();
			pc = draw_random();
			pc[1:0] = 2'b00;
			idx = 5'(sel[31:8] % 25);
			// three times in four the opcode comes from the legal list
			if (sel[1:0] != 2'b00)
				w = {LEGAL_OPS[idx], body[24:0]};
			else
				w = body;
			f = (sel[4:2] != 3'b000);
			ex = (sel[7:5] == 3'b000);
			instr <= w;
			pc_plus_4 <= pc;
			fetched <= f;
			exception_start_in <= ex;
			@(negedge clk);
			check_registered();
			check_combinational();
			predict(w, pc, f, ex);
		end
		@(posedge clk);
		@(negedge clk);
		check_registered();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Test failed");
		$finish;
	end

endmodule
